//--- Makefile
TOP = tb_icache

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f icache_top.f

run: compile
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "Simulation completed successfully"

clean:
	rm -rf obj_dir

.PHONY: all compile run clean

//--- icache_checker.sv
`timescale 1ns/100ps

module icache_checker (
  input logic                     clk,
  input logic                     rst,
  input logic                     ok,
  input logic                     miss,
  input logic                     sen,
  input icache_pkg::addr_t        addr,
  input icache_pkg::ctrl_state_t  state
);
  import icache_pkg::*;

  int assert_failures = 0;

  ok_one_cycle: assert property (@(posedge clk) disable iff (rst) ok |=> !ok)
    else
    begin
      $error("ok stayed high for more than one cycle");
      assert_failures++;
    end

  addr_stable: assert property (@(posedge clk) disable iff (rst)
    (sen && $past(sen)) |-> $stable(addr))
    else
    begin
      $error("addr changed while sen was high");
      assert_failures++;
    end

  quiet_in_reset: assert property (@(posedge clk) rst |-> (!ok && !sen))
    else
    begin
      $error("ok or sen high during reset");
      assert_failures++;
    end

  no_miss_with_ok: assert property (@(posedge clk) disable iff (rst) !(miss && ok))
    else
    begin
      $error("miss and ok high in the same cycle");
      assert_failures++;
    end

  // Burst only runs while the controller waits in refill
  sen_in_refill: assert property (@(posedge clk) disable iff (rst)
    sen |-> state == ST_REFILL)
    else
    begin
      $error("sen high outside the refill state");
      assert_failures++;
    end

endmodule

bind icache_top icache_checker u_checker (
  .clk   (clk),
  .rst   (rst),
  .ok    (ok),
  .miss  (miss),
  .sen   (sen),
  .addr  (addr),
  .state (u_ctrl.state)
);

//--- icache_ctrl.sv
`timescale 1ns/100ps

module icache_ctrl (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   req,
  input  icache_pkg::addr_t      insaddr,
  output icache_pkg::word_t      ins,
  output logic                   ok,
  output logic                   miss,
  output icache_pkg::set_t       lk_set,
  output icache_pkg::tag_t       lk_tag,
  output icache_pkg::word_sel_t  lk_word,
  input  logic                   hit,
  input  icache_pkg::way_t       hit_way,
  input  icache_pkg::way_t       victim_way,
  output logic                   touch,
  output icache_pkg::way_t       touch_way,
  input  icache_pkg::word_t      rd_data,
  output logic                   refill_start,
  output icache_pkg::addr_t      refill_addr,
  output icache_pkg::way_t       refill_way,
  icache_fill_if.mon             fill
);
  import icache_pkg::*;

  ctrl_state_t state;
  ctrl_state_t state_next;
  addr_t       req_addr;

  ////////////////////////////////////////////////////////////
  // Request FSM
  ////////////////////////////////////////////////////////////

  always_comb
  begin
    state_next = state;
    case (state)
      ST_IDLE:
        if (req)
          state_next = ST_LOOKUP;
      ST_LOOKUP:
        state_next = hit ? ST_IDLE : ST_REFILL;
      ST_REFILL:
        if (fill.last)
          state_next = ST_IDLE;
      default:
        state_next = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
      state <= ST_IDLE;
    else
      state <= state_next;
  end

  always_ff @(posedge clk)
  begin
    if (state == ST_IDLE && req)
      req_addr <= insaddr;
  end

  assign lk_tag  = req_addr[ADDR_W - 1 -: TAG_W];
  assign lk_set  = req_addr[WORD_SEL_W + 2 +: SET_W];
  assign lk_word = req_addr[2 +: WORD_SEL_W];

  ////////////////////////////////////////////////////////////
  // Processor and refill outputs
  ////////////////////////////////////////////////////////////

  assign touch     = state == ST_LOOKUP && hit;
  assign touch_way = hit_way;
  assign miss      = state == ST_LOOKUP && !hit;

  // Critical word goes out as it arrives
  assign ok  = touch || (state == ST_REFILL && fill.first);
  assign ins = (state == ST_REFILL) ? fill.data : rd_data;

  assign refill_start = miss;
  assign refill_addr  = {req_addr[ADDR_W - 1:2], 2'b00};
  assign refill_way   = victim_way;

endmodule

//--- icache_data_array.sv
`timescale 1ns/100ps

module icache_data_array (
  input  logic                   clk,
  input  icache_pkg::set_t       lk_set,
  input  icache_pkg::word_sel_t  lk_word,
  input  icache_pkg::way_t       hit_way,
  output icache_pkg::word_t      rd_data,
  icache_fill_if.data_wr         fill
);
  import icache_pkg::*;

  ////////////////////////////////////////////////////////////
  // Line storage, way x set x word
  ////////////////////////////////////////////////////////////

  word_t mem [NUM_WAYS][2**SET_W][LINE_WORDS];

  // One word per strobe, straight into the chosen way
  always_ff @(posedge clk)
  begin
    if (fill.we)
      mem[fill.way][fill.set][fill.word] <= fill.data;
  end

  assign rd_data = mem[hit_way][lk_set][lk_word];

endmodule

//--- icache_fill_if.sv
`timescale 1ns/100ps

interface icache_fill_if;
  import icache_pkg::*;

  logic      we;
  way_t      way;
  set_t      set;
  word_sel_t word;
  tag_t      tag;
  word_t     data;
  logic      first;
  logic      last;

  modport seq     (output we, way, set, word, tag, data, first, last);
  modport data_wr (input we, way, set, word, data);
  modport tag_wr  (input last, way, set, tag);
  modport mon     (input first, last, data);

endinterface

//--- icache_pkg.sv
package icache_pkg;

  ////////////////////////////////////////////////////////////
  // Geometry
  ////////////////////////////////////////////////////////////

  localparam int ADDR_W     = 32;
  localparam int TAG_W      = 22;
  localparam int SET_W      = 4;
  localparam int WORD_SEL_W = 4;
  localparam int NUM_WAYS   = 4;
  localparam int LINE_WORDS = 16;
  localparam int AGE_W      = 2;

  ////////////////////////////////////////////////////////////
  // Types
  ////////////////////////////////////////////////////////////

  typedef logic [ADDR_W-1:0]     addr_t;
  typedef logic [31:0]           word_t;
  typedef logic [TAG_W-1:0]      tag_t;
  typedef logic [SET_W-1:0]      set_t;
  typedef logic [WORD_SEL_W-1:0] word_sel_t;
  typedef logic [1:0]            way_t;
  typedef logic [AGE_W-1:0]      age_t;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_LOOKUP,
    ST_REFILL
  } ctrl_state_t;

endpackage

//--- icache_refill.sv
`timescale 1ns/100ps

module icache_refill (
  input  logic               clk,
  input  logic               rst,
  input  logic               refill_start,
  input  icache_pkg::addr_t  refill_addr,
  input  icache_pkg::way_t   refill_way,
  output logic               sen,
  output icache_pkg::addr_t  addr,
  input  logic               data_ok,
  input  icache_pkg::word_t  sdata,
  icache_fill_if.seq         fill
);
  import icache_pkg::*;

  way_t      way_q;
  word_sel_t cnt;
  word_sel_t start_word;
  logic      strobe;
  logic      final_word;

  ////////////////////////////////////////////////////////////
  // Burst control
  ////////////////////////////////////////////////////////////

  assign strobe     = sen & data_ok;
  assign final_word = cnt == word_sel_t'(LINE_WORDS - 1);

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      sen <= 1'b0;
      cnt <= '0;
    end
    else if (refill_start)
    begin
      sen <= 1'b1;
      cnt <= '0;
    end
    else if (strobe)
    begin
      // Counter wraps back to zero on the last word
      cnt <= cnt + 1'b1;
      if (final_word)
        sen <= 1'b0;
    end
  end

  // Miss address and way held for the whole burst
  always_ff @(posedge clk)
  begin
    if (refill_start)
    begin
      addr  <= refill_addr;
      way_q <= refill_way;
    end
  end

  ////////////////////////////////////////////////////////////
  // Write port
  ////////////////////////////////////////////////////////////

  assign start_word = addr[2 +: WORD_SEL_W];

  assign fill.we    = strobe;
  assign fill.way   = way_q;
  assign fill.set   = addr[WORD_SEL_W + 2 +: SET_W];
  assign fill.tag   = addr[ADDR_W - 1 -: TAG_W];
  assign fill.word  = start_word + cnt;
  assign fill.data  = sdata;
  assign fill.first = strobe & (cnt == '0);
  assign fill.last  = strobe & final_word;

endmodule

//--- icache_tag_store.sv
`timescale 1ns/100ps

module icache_tag_store (
  input  logic              clk,
  input  logic              rst,
  input  icache_pkg::set_t  lk_set,
  input  icache_pkg::tag_t  lk_tag,
  output logic              hit,
  output icache_pkg::way_t  hit_way,
  output icache_pkg::way_t  victim_way,
  input  logic              touch,
  input  icache_pkg::way_t  touch_way,
  icache_fill_if.tag_wr     fill
);
  import icache_pkg::*;

  tag_t                tags  [2**SET_W][NUM_WAYS];
  logic [NUM_WAYS-1:0] valid [2**SET_W];
  age_t                ages  [2**SET_W][NUM_WAYS];

  logic upd;
  set_t upd_set;
  way_t upd_way;
  age_t prev_age;
  logic found_inv;

  // Lowest matching way wins
  always_comb
  begin
    hit = 1'b0;
    hit_way = '0;
    for (int w = NUM_WAYS - 1; w >= 0; w--)
    begin
      if (valid[lk_set][w] && tags[lk_set][w] == lk_tag)
      begin
        hit = 1'b1;
        hit_way = way_t'(w);
      end
    end
  end

  // Invalid way first, else oldest
  always_comb
  begin
    victim_way = '0;
    found_inv = 1'b0;
    for (int w = 0; w < NUM_WAYS; w++)
    begin
      if (!valid[lk_set][w] && !found_inv)
      begin
        victim_way = way_t'(w);
        found_inv = 1'b1;
      end
    end
    if (!found_inv)
    begin
      for (int w = 1; w < NUM_WAYS; w++)
      begin
        if (ages[lk_set][w] > ages[lk_set][victim_way])
          victim_way = way_t'(w);
      end
    end
  end

  assign upd      = touch | fill.last;
  assign upd_set  = touch ? lk_set : fill.set;
  assign upd_way  = touch ? touch_way : fill.way;
  assign prev_age = ages[upd_set][upd_way];

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      for (int s = 0; s < 2**SET_W; s++)
      begin
        valid[s] <= '0;
        for (int w = 0; w < NUM_WAYS; w++)
          ages[s][w] <= '0;
      end
    end
    else
    begin
      if (fill.last)
        valid[fill.set][fill.way] <= 1'b1;
      if (upd)
      begin
        for (int w = 0; w < NUM_WAYS; w++)
        begin
          if (way_t'(w) == upd_way)
            ages[upd_set][w] <= '0;
          else if (ages[upd_set][w] <= prev_age && ages[upd_set][w] != '1)
            ages[upd_set][w] <= ages[upd_set][w] + 1'b1;
        end
      end
    end
  end

  // Tag lands with the final word of the burst
  always_ff @(posedge clk)
  begin
    if (fill.last)
      tags[fill.set][fill.way] <= fill.tag;
  end

endmodule

//--- icache_top.f
icache_pkg.sv
icache_fill_if.sv
icache_tag_store.sv
icache_data_array.sv
icache_refill.sv
icache_ctrl.sv
icache_top.sv
icache_checker.sv
tb_icache.sv

//--- icache_top.sv
`timescale 1ns/100ps

module icache_top (
  input  logic               clk,
  input  logic               rst,
  input  logic               req,
  input  icache_pkg::addr_t  insaddr,
  output icache_pkg::word_t  ins,
  output logic               ok,
  output logic               miss,
  output logic               sen,
  output icache_pkg::addr_t  addr,
  input  logic               data_ok,
  input  icache_pkg::word_t  sdata
);
  import icache_pkg::*;

  set_t      lk_set;
  tag_t      lk_tag;
  word_sel_t lk_word;
  logic      hit;
  way_t      hit_way;
  way_t      victim_way;
  logic      touch;
  way_t      touch_way;
  word_t     rd_data;
  logic      refill_start;
  addr_t     refill_addr;
  way_t      refill_way;

  icache_fill_if fill_bus ();

  icache_ctrl u_ctrl (
    .clk          (clk),
    .rst          (rst),
    .req          (req),
    .insaddr      (insaddr),
    .ins          (ins),
    .ok           (ok),
    .miss         (miss),
    .lk_set       (lk_set),
    .lk_tag       (lk_tag),
    .lk_word      (lk_word),
    .hit          (hit),
    .hit_way      (hit_way),
    .victim_way   (victim_way),
    .touch        (touch),
    .touch_way    (touch_way),
    .rd_data      (rd_data),
    .refill_start (refill_start),
    .refill_addr  (refill_addr),
    .refill_way   (refill_way),
    .fill         (fill_bus.mon)
  );

  icache_tag_store u_tag_store (
    .clk        (clk),
    .rst        (rst),
    .lk_set     (lk_set),
    .lk_tag     (lk_tag),
    .hit        (hit),
    .hit_way    (hit_way),
    .victim_way (victim_way),
    .touch      (touch),
    .touch_way  (touch_way),
    .fill       (fill_bus.tag_wr)
  );

  icache_data_array u_data_array (
    .clk     (clk),
    .lk_set  (lk_set),
    .lk_word (lk_word),
    .hit_way (hit_way),
    .rd_data (rd_data),
    .fill    (fill_bus.data_wr)
  );

  icache_refill u_refill (
    .clk          (clk),
    .rst          (rst),
    .refill_start (refill_start),
    .refill_addr  (refill_addr),
    .refill_way   (refill_way),
    .sen          (sen),
    .addr         (addr),
    .data_ok      (data_ok),
    .sdata        (sdata),
    .fill         (fill_bus.seq)
  );

endmodule

//--- icache_trace.txt
// entry count, then one row per request:
// address  expected_miss  expected_ins  early (raised while a refill streams)
16
00002468 1 FFFFDB97 0
00002440 0 FFFFDBBF 0
0000247C 0 FFFFDB83 0
00002464 0 FFFFDB9B 0
0000414C 1 FFFFBEB3 0
00004544 1 FFFFBABB 0
00004978 1 FFFFB687 0
00004D40 1 FFFFB2BF 0
00004140 0 FFFFBEBF 0
0000457C 0 FFFFBA83 0
00004950 0 FFFFB6AF 0
00004D60 0 FFFFB29F 0
00004548 0 FFFFBAB7 0
00004944 0 FFFFB6BB 0
00004D44 0 FFFFB2BB 0
0000515C 1 FFFFAEA3 0
00004540 0 FFFFBABF 0
00004940 0 FFFFB6BF 0
00004D7C 0 FFFFB283 0
00004150 1 FFFFBEAF 0
0000ABC0 1 FFFF543F 1
00002450 0 FFFFDBAF 1

//--- tb_icache.sv
`timescale 1ns/100ps

module tb_icache;
  import icache_pkg::*;

  logic        clk;
  logic        rst;
  logic        req;
  addr_t       insaddr;
  word_t       ins;
  logic        ok;
  logic        miss;
  logic        sen;
  addr_t       addr;
  logic        data_ok;
  word_t       sdata;

  logic [31:0] trace_mem [128];
  logic [16:0] lfsr;
  logic [4:0]  beats;
  logic [1:0]  gap;
  int          cycles;
  int          cycle_limit = 100000;
  int          num_entries;
  int          tests_passed;
  int          tests_failed;

  icache_top u_dut (
    .clk     (clk),
    .rst     (rst),
    .req     (req),
    .insaddr (insaddr),
    .ins     (ins),
    .ok      (ok),
    .miss    (miss),
    .sen     (sen),
    .addr    (addr),
    .data_ok (data_ok),
    .sdata   (sdata)
  );

  initial
  begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  initial
  begin
    cycles = 0;
    while (cycles <= cycle_limit)
    begin
      @(posedge clk);
      cycles++;
    end
    $display("Run stopped after %0d cycles, the cycle limit was reached", cycles);
    $display("Simulation failed");
    $finish;
  end

  ////////////////////////////////////////////////////////////
  // Memory model
  ////////////////////////////////////////////////////////////

  // Fibonacci LFSR with taps 17 and 14
  function automatic logic next_random_bit();
    logic fb;
    fb = lfsr[16] ^ lfsr[13];
    lfsr = {lfsr[15:0], fb};
    return fb;
  endfunction

  function automatic logic [1:0] random_gap();
    logic [1:0] g;
    g[1] = next_random_bit();
    g[0] = next_random_bit();
    return g;
  endfunction

  // Wraps inside the 16-word line
  function automatic addr_t beat_address(addr_t base, logic [3:0] beat);
    logic [3:0] idx;
    idx = base[5:2] + beat;
    return {base[31:6], idx, 2'b00};
  endfunction

  initial
  begin
    data_ok = 1'b0;
    sdata = '0;
    beats = '0;
    gap = '0;
    forever
    begin
      @(posedge clk);
      #1;
      data_ok = 1'b0;
      if (!sen)
      begin
        beats = '0;
        gap = '0;
      end
      else if (beats < 5'd16)
      begin
        if (gap != 2'd0)
          gap = gap - 2'd1;
        else
        begin
          sdata = ~beat_address(addr, beats[3:0]);
          data_ok = 1'b1;
          beats = beats + 5'd1;
          gap = random_gap();
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////

  task automatic record_result(string name, int errs);
    if (errs == 0)
    begin
      tests_passed++;
      $display("%s: pass", name);
    end
    else
    begin
      tests_failed++;
      $display("%s: %0d problems", name, errs);
    end
  endtask

  task automatic check_idle_after_reset();
    int errs;
    errs = 0;
    repeat (8)
    begin
      @(negedge clk);
      if (ok !== 1'b0 || miss !== 1'b0 || sen !== 1'b0)
      begin
        $display("FAIL reset idle: ok = %h, miss = %h, sen = %h, expected 0", ok, miss, sen);
        errs++;
      end
    end
    record_result("reset idle", errs);
  endtask

  task automatic run_entry(int i);
    addr_t a;
    logic  exp_miss;
    word_t exp_ins;
    logic  early;
    logic  prior_refill;
    logic  miss_seen;
    logic  sen_seen;
    addr_t sen_addr;
    int    waited;
    int    errs;
    a = trace_mem[1 + 4*i];
    exp_miss = trace_mem[2 + 4*i][0];
    exp_ins = trace_mem[3 + 4*i];
    early = trace_mem[4 + 4*i][0];
    errs = 0;
    miss_seen = 1'b0;
    sen_seen = 1'b0;
    sen_addr = '0;
    waited = 0;
    @(posedge clk);
    #1;
    if (early && !sen)
    begin
      $display("entry %0d: no refill was streaming when the early request was raised", i);
      errs++;
    end
    while (!early && sen)
    begin
      @(posedge clk);
      #1;
    end
    prior_refill = sen;
    req = 1'b1;
    insaddr = a;
    do
    begin
      @(negedge clk);
      waited++;
      if (!sen)
        prior_refill = 1'b0;
      if (miss)
        miss_seen = 1'b1;
      if (sen && !prior_refill && !sen_seen)
      begin
        sen_seen = 1'b1;
        sen_addr = addr;
      end
    end
    while (!ok);
    if (prior_refill)
    begin
      $display("entry %0d: request answered before the running refill ended", i);
      errs++;
    end
    if (ins !== exp_ins)
    begin
      $display("FAIL entry %0d: ins = %h, expected %h", i, ins, exp_ins);
      errs++;
    end
    if (miss_seen !== exp_miss)
    begin
      $display("FAIL entry %0d: miss = %h, expected %h", i, miss_seen, exp_miss);
      errs++;
    end
    if (exp_miss && !sen_seen)
    begin
      $display("entry %0d: the miss started no refill", i);
      errs++;
    end
    if (exp_miss && sen_seen && sen_addr !== a)
    begin
      $display("FAIL entry %0d: addr = %h, expected %h", i, sen_addr, a);
      errs++;
    end
    if (exp_miss && !data_ok)
    begin
      $display("entry %0d: ok for the miss came without a data_ok strobe", i);
      errs++;
    end
    if (!exp_miss && sen_seen)
    begin
      $display("entry %0d: a refill was started for a hit", i);
      errs++;
    end
    if (!exp_miss && !early && waited != 2)
    begin
      $display("entry %0d: hit answered after %0d cycles instead of 2", i, waited);
      errs++;
    end
    @(posedge clk);
    #1;
    req = 1'b0;
    record_result($sformatf("entry %0d addr %h", i, a), errs);
  endtask

  ////////////////////////////////////////////////////////////
  // Test flow
  ////////////////////////////////////////////////////////////

  initial
  begin
    rst = 1'b1;
    req = 1'b0;
    insaddr = '0;
    lfsr = 17'd73539;
    tests_passed = 0;
    tests_failed = 0;
    $readmemh("icache_trace.txt", trace_mem);
    num_entries = int'(trace_mem[0]);
    cycle_limit = 80 * num_entries + 50;
    repeat (5) @(posedge clk);
    #1;
    rst = 1'b0;
    check_idle_after_reset();
    for (int i = 0; i < num_entries; i++)
      run_entry(i);
    $display("%0d tests, %0d passed, %0d failed, %0d assertion failures",
             tests_passed + tests_failed, tests_passed, tests_failed,
             u_dut.u_checker.assert_failures);
    if (tests_failed == 0 && u_dut.u_checker.assert_failures == 0)
      $display("Simulation completed successfully");
    else
      $display("Simulation failed");
    $finish;
  end

endmodule
